// File: verilog.f
ringPkg.sv
ringIf.sv
ringStop.sv
memTile.sv
hostTile.sv
ringTop.sv
tbRingTop.sv

// File: Makefile
# Verilator build for the ring interconnect testbench
# usage: make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= tbRingTop
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BINARY = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the log holds the pass line
run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@grep -q "^TEST PASS$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tbRingTop.sv
/*
 * testbench for the ring top
 * random host traffic checked against a memory model, matched by tag
 */
`timescale 1ns/1ps
module tbRingTop;
    import ringPkg::*;

    localparam int NumInitOps    = NumMemTiles * MemWords;   // one write per word
    localparam int NumRandomOps  = 400;
    localparam int CyclesPerOp   = 64;
    localparam int TimeoutCycles = (NumInitOps + NumRandomOps) * CyclesPerOp;

    logic    QClk;
    logic    reset;
    logic    hostReqValid, hostReqWrite, hostReqReady;
    tAddress hostReqAddress;
    tData    hostReqData;
    tTag     hostReqTag;
    logic    hostRspValid, hostRspError, hostRspReady;
    tTag     hostRspTag;
    tData    hostRspData;

    ringTop UUT (
        .QClk           (QClk),
        .reset          (reset),
        .hostReqValid   (hostReqValid),
        .hostReqWrite   (hostReqWrite),
        .hostReqAddress (hostReqAddress),
        .hostReqData    (hostReqData),
        .hostReqReady   (hostReqReady),
        .hostReqTag     (hostReqTag),
        .hostRspValid   (hostRspValid),
        .hostRspError   (hostRspError),
        .hostRspTag     (hostRspTag),
        .hostRspData    (hostRspData),
        .hostRspReady   (hostRspReady)
    );

    initial begin
        QClk = 1'b0;
        forever #4 QClk = ~QClk;    // 8 ns period
    end

    //==================================================
    // model state
    //==================================================
    tData        modelMem [NumMemTiles][MemWords];
    logic        expBusy [NumTags];     // tag outstanding
    logic        expError [NumTags];
    logic        expRead [NumTags];
    tData        expData [NumTags];
    tAddress     expAddress [NumTags];
    logic [31:0] rngState;
    int          dataErrors, tagErrors, flagErrors;
    int          issuedCount, answeredCount, cycleCount, burstLeft;
    logic        reqPending, reqWrite, draining, readyNow;
    tAddress     reqAddress;
    tData        reqData;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic isMapped(input tCoreId core);
        return (core >= 8'd2) && (core <= 8'd4);
    endfunction

    // tags are handed out lowest free first
    function automatic tTag lowestFree();
        tTag t;
        t = '0;
        for (int i = NumTags - 1; i >= 0; i--) begin
            if (!expBusy[i]) t = tTag'(i);
        end
        return t;
    endfunction

    function automatic int numBusy();
        int n;
        n = 0;
        for (int i = 0; i < NumTags; i++) n += int'(expBusy[i]);
        return n;
    endfunction

    // outstanding read to the same word of the same core
    function automatic logic readPending(input tAddress addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NumTags; i++) begin
            if (expBusy[i] && expRead[i] && expAddress[i][31:24] == addr[31:24]
                    && expAddress[i][5:2] == addr[5:2]) hit = 1'b1;
        end
        return hit;
    endfunction

    //==================================================
    // compare tasks
    //==================================================
    task automatic checkData(input string name, input tData got, input tData exp);
        if (got !== exp) begin
            dataErrors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkTag(input string name, input tTag got, input tTag exp);
        if (got !== exp) begin
            tagErrors++;
            $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flagErrors++;
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //==================================================
    // one clock cycle, drive on falling edge
    //==================================================
    task automatic runCycle();
        logic [31:0] r;
        tTag         t;
        tCoreId      core;
        @(negedge QClk);
        if (draining) begin
            readyNow = 1'b1;
        end else if (burstLeft == 0) begin
            r = nextRand();
            readyNow  = r[1:0] != 2'b00;                  // mostly ready
            burstLeft = readyNow ? int'(r[7:4]) + 1 : int'(r[12:8]) + 1;
        end
        if (burstLeft > 0) burstLeft--;
        hostRspReady   = readyNow;
        hostReqValid   = reqPending;
        hostReqWrite   = reqWrite;
        hostReqAddress = reqAddress;
        hostReqData    = reqData;
        #1;                                                // settle before sampling
        // request side first, tag frees only at the edge
        if (reqPending) begin
            if (numBusy() == NumTags) checkFlag("hostReqReady", hostReqReady, 1'b0);
            if (hostReqReady) begin
                checkTag("hostReqTag", hostReqTag, lowestFree());
                t    = hostReqTag;
                core = reqAddress[31:24];
                expBusy[t]    = 1'b1;
                expError[t]   = !isMapped(core);
                expRead[t]    = !reqWrite;
                expAddress[t] = reqAddress;
                expData[t]    = '0;
                if (isMapped(core)) begin
                    if (reqWrite) modelMem[core - 8'd2][reqAddress[5:2]] = reqData;
                    else expData[t] = modelMem[core - 8'd2][reqAddress[5:2]];
                end
                issuedCount++;
                reqPending = 1'b0;
            end
        end
        if (hostRspValid && hostRspReady) begin
            t = hostRspTag;
            checkFlag("tag outstanding", expBusy[t], 1'b1);
            if (expBusy[t]) begin
                checkFlag("hostRspError", hostRspError, expError[t]);
                if (!expError[t] && expRead[t]) checkData("hostRspData", hostRspData, expData[t]);
            end
            expBusy[t] = 1'b0;
            answeredCount++;
        end
    endtask

    task automatic issueOp(input logic write, input tAddress addr, input tData data);
        reqWrite   = write;
        reqAddress = addr;
        reqData    = data;
        reqPending = 1'b1;
        while (reqPending) runCycle();                     // back to back requests
    endtask

    // hang guard
    always @(posedge QClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout after %0d cycles, %0d requests still unanswered",
                     TimeoutCycles, numBusy());
            $display("TEST FAIL");
            $finish;
        end
    end

    //==================================================
    // main sequence
    //==================================================
    initial begin
        logic [31:0] rCore, rWord;
        tCoreId      core;
        tAddress     addr;
        logic        write;
        rngState       = 32'd36896;
        reset          = 1'b1;
        hostReqValid   = 1'b0;
        hostReqWrite   = 1'b0;
        hostReqAddress = '0;
        hostReqData    = '0;
        hostRspReady   = 1'b0;
        reqPending     = 1'b0;
        reqWrite       = 1'b0;
        reqAddress     = '0;
        reqData        = '0;
        draining       = 1'b0;
        readyNow       = 1'b1;
        burstLeft      = 0;
        for (int i = 0; i < NumTags; i++) expBusy[i] = 1'b0;
        repeat (3) @(posedge QClk);
        @(negedge QClk);
        reset = 1'b0;
        #1;
        checkFlag("hostRspValid", hostRspValid, 1'b0);

        // fill every word so no read sees unset memory
        for (int c = 0; c < NumMemTiles; c++) begin
            for (int w = 0; w < MemWords; w++) begin
                addr = {tCoreId'(c + 2), 18'd0, tWordIdx'(w), 2'b00};
                issueOp(1'b1, addr, nextRand());
            end
        end

        for (int n = 0; n < NumRandomOps; n++) begin
            rCore = nextRand();
            rWord = nextRand();
            write = rCore[31];
            if (rCore[2:0] < 3'd6) begin
                core = (rCore[15:8] % 8'd3) + 8'd2;       // memory tile
            end else begin
                core = rCore[15:8];                         // likely unmapped
                if (isMapped(core)) core = core + 8'd3;
            end
            addr = {core, rWord[17:0], rWord[21:18], 2'b00};
            if (write && readPending(addr)) write = 1'b0;   // keep read data defined
            issueOp(write, addr, nextRand());
        end

        draining = 1'b1;
        while (numBusy() != 0) runCycle();
        repeat (20) runCycle();                             // catch late duplicates
        checkFlag("all requests answered", issuedCount == answeredCount, 1'b1);

        $display("errors: data %0d, tag %0d, flag %0d (requests %0d, responses %0d)",
                 dataErrors, tagErrors, flagErrors, issuedCount, answeredCount);
        if (dataErrors + tagErrors + flagErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: ringTop.sv
/*
 * ring top, host tile plus three memory tiles
 * request and response rings closed back to the host
 */
`timescale 1ns/1ps
module ringTop (
    input  logic             QClk,
    input  logic             reset,
    input  logic             hostReqValid,
    input  logic             hostReqWrite,
    input  ringPkg::tAddress hostReqAddress,
    input  ringPkg::tData    hostReqData,
    output logic             hostReqReady,
    output ringPkg::tTag     hostReqTag,
    output logic             hostRspValid,
    output logic             hostRspError,
    output ringPkg::tTag     hostRspTag,
    output ringPkg::tData    hostRspData,
    input  logic             hostRspReady
);
    import ringPkg::*;

    // link k feeds tile k, host is tile 0
    ringIf reqLink [NumMemTiles+1] ();
    ringIf rspLink [NumMemTiles+1] ();

    hostTile host (
        .QClk           (QClk),
        .reset          (reset),
        .reqIn          (reqLink[0]),
        .rspIn          (rspLink[0]),
        .reqOut         (reqLink[1]),
        .rspOut         (rspLink[1]),
        .hostReqValid   (hostReqValid),
        .hostReqWrite   (hostReqWrite),
        .hostReqAddress (hostReqAddress),
        .hostReqData    (hostReqData),
        .hostReqReady   (hostReqReady),
        .hostReqTag     (hostReqTag),
        .hostRspValid   (hostRspValid),
        .hostRspError   (hostRspError),
        .hostRspTag     (hostRspTag),
        .hostRspData    (hostRspData),
        .hostRspReady   (hostRspReady)
    );

    //==================================================
    // memory tiles, ids 2 up, last one closes the ring
    //==================================================
    genvar tile;
    generate
        for (tile = 0; tile < NumMemTiles; tile++) begin : genMemTiles
            memTile #(.CoreId(tCoreId'(tile + 2))) mem (
                .QClk   (QClk),
                .reset  (reset),
                .reqIn  (reqLink[tile+1]),
                .rspIn  (rspLink[tile+1]),
                .reqOut (reqLink[(tile+2) % (NumMemTiles+1)]),
                .rspOut (rspLink[(tile+2) % (NumMemTiles+1)])
            );
        end
    endgenerate

endmodule

// File: hostTile.sv
/*
 * host tile, tags host requests and injects them on the request ring
 * holds returned responses by tag until the host takes them
 */
`timescale 1ns/1ps
module hostTile (
    input  logic             QClk,
    input  logic             reset,
    ringIf.dst               reqIn,
    ringIf.dst               rspIn,
    ringIf.src               reqOut,
    ringIf.src               rspOut,
    input  logic             hostReqValid,
    input  logic             hostReqWrite,
    input  ringPkg::tAddress hostReqAddress,
    input  ringPkg::tData    hostReqData,
    output logic             hostReqReady,
    output ringPkg::tTag     hostReqTag,
    output logic             hostRspValid,
    output logic             hostRspError,
    output ringPkg::tTag     hostRspTag,
    output ringPkg::tData    hostRspData,
    input  logic             hostRspReady
);
    import ringPkg::*;

    ringIf reqLocal ();
    ringIf rspLocal ();
    ringIf reqInj ();
    ringIf rspInj ();
    logic  reqTaken;

    ringStop #(.CoreId(tCoreId'(HostCoreId))) stop (
        .QClk        (QClk),
        .reset       (reset),
        .reqIn       (reqIn),
        .rspIn       (rspIn),
        .reqOut      (reqOut),
        .rspOut      (rspOut),
        .reqLocal    (reqLocal),
        .rspLocal    (rspLocal),
        .reqInj      (reqInj),
        .rspInj      (rspInj),
        .reqInjTaken (reqTaken),
        .rspInjTaken ()             // host never answers requests
    );

    assign rspInj.valid     = 1'b0;
    assign rspInj.requestor = '0;
    assign rspInj.opcode    = OpRdRsp;
    assign rspInj.address   = '0;
    assign rspInj.data      = '0;

    //==================================================
    // request side
    //==================================================
    logic [NumTags-1:0] tagFree;
    logic [NumTags-1:0] rspHeld;

    assign hostReqTag       = lowestSet(tagFree);
    assign reqInj.valid     = hostReqValid && |tagFree;
    assign reqInj.requestor = {tCoreId'(HostCoreId), hostReqTag};
    assign reqInj.opcode    = hostReqWrite ? OpWrite : OpRead;
    assign reqInj.address   = hostReqAddress;
    assign reqInj.data      = hostReqData;
    assign hostReqReady     = reqTaken;     // transfer = stop accepts

    //==================================================
    // response side
    //==================================================
    logic heldError [NumTags];
    tData heldData [NumTags];
    logic presenting;                       // host saw valid, tag locked
    tTag  lockedTag;
    tTag  rspTag;
    logic rspXfer;

    assign rspTag       = tagOf(rspLocal.requestor);
    assign hostRspValid = presenting || |rspHeld;
    assign hostRspTag   = presenting ? lockedTag : lowestSet(rspHeld);
    assign hostRspError = heldError[hostRspTag];
    assign hostRspData  = heldData[hostRspTag];
    assign rspXfer      = hostRspValid && hostRspReady;

    always_ff @(posedge QClk) begin
        if (reset) begin
            tagFree    <= '1;
            rspHeld    <= '0;
            presenting <= 1'b0;
        end else begin
            if (reqTaken) tagFree[hostReqTag] <= 1'b0;
            if (rspLocal.valid) rspHeld[rspTag] <= 1'b1;
            if (rspXfer) begin
                tagFree[hostRspTag] <= 1'b1;
                rspHeld[hostRspTag] <= 1'b0;
            end
            presenting <= hostRspValid && !hostRspReady;
        end
        if (hostRspValid && !presenting) lockedTag <= hostRspTag;
        if (rspLocal.valid) begin
            heldError[rspTag] <= rspLocal.address[0];
            heldData[rspTag]  <= rspLocal.data;
        end
    end

    // response only for an outstanding, not yet held tag
    assert property (@(posedge QClk) disable iff (reset)
        rspLocal.valid |-> !tagFree[rspTag] && !rspHeld[rspTag]);
    // offered response holds until taken
    assert property (@(posedge QClk) disable iff (reset)
        hostRspValid && !hostRspReady |=> hostRspValid && $stable(hostRspTag));
    assert property (@(posedge QClk) disable iff (reset) !reqLocal.valid);

endmodule

// File: memTile.sv
/*
 * memory tile, 16 words behind a ring stop
 * executes requests and queues responses for the response ring
 */
`timescale 1ns/1ps
module memTile #(
    parameter ringPkg::tCoreId CoreId = 8'd2
) (
    input logic QClk,
    input logic reset,
    ringIf.dst  reqIn,
    ringIf.dst  rspIn,
    ringIf.src  reqOut,
    ringIf.src  rspOut
);
    import ringPkg::*;

    ringIf reqLocal ();
    ringIf rspLocal ();
    ringIf reqInj ();
    ringIf rspInj ();
    logic  rspTaken;

    ringStop #(.CoreId(CoreId)) stop (
        .QClk        (QClk),
        .reset       (reset),
        .reqIn       (reqIn),
        .rspIn       (rspIn),
        .reqOut      (reqOut),
        .rspOut      (rspOut),
        .reqLocal    (reqLocal),
        .rspLocal    (rspLocal),
        .reqInj      (reqInj),
        .rspInj      (rspInj),
        .reqInjTaken (),            // tile never issues requests
        .rspInjTaken (rspTaken)
    );

    assign reqInj.valid     = 1'b0;
    assign reqInj.requestor = '0;
    assign reqInj.opcode    = OpRead;
    assign reqInj.address   = '0;
    assign reqInj.data      = '0;

    //==================================================
    // store and response queue
    //==================================================
    tData      mem [MemWords];
    tRequestor qRequestor [RspQueueDepth];
    tOpcode    qOpcode [RspQueueDepth];
    tAddress   qAddress [RspQueueDepth];
    tData      qData [RspQueueDepth];

    logic [QueuePtrWidth-1:0] wrPtr, rdPtr;
    logic [QueuePtrWidth:0]   count;     // one bit wider, holds full
    logic push, pop, full, isWrite;
    tWordIdx word;

    assign push    = reqLocal.valid;
    assign pop     = rspTaken;
    assign full    = count == (QueuePtrWidth + 1)'(RspQueueDepth);
    assign isWrite = reqLocal.opcode == OpWrite;
    assign word    = wordOf(reqLocal.address);

    always_ff @(posedge QClk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop) rdPtr <= rdPtr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge QClk) begin
        if (push) begin
            if (isWrite) mem[word] <= reqLocal.data;
            qRequestor[wrPtr] <= reqLocal.requestor;
            qOpcode[wrPtr]    <= isWrite ? OpWrRsp : OpRdRsp;
            qAddress[wrPtr]   <= {reqLocal.address[31:2], 2'b00};   // no error
            qData[wrPtr]      <= isWrite ? reqLocal.data : mem[word];  // old word on read
        end
    end

    // head offered until the stop takes it
    assign rspInj.valid     = count != '0;
    assign rspInj.requestor = qRequestor[rdPtr];
    assign rspInj.opcode    = qOpcode[rdPtr];
    assign rspInj.address   = qAddress[rdPtr];
    assign rspInj.data      = qData[rdPtr];

    assert property (@(posedge QClk) disable iff (reset) full |-> !push);
    // nobody addresses responses to a memory tile
    assert property (@(posedge QClk) disable iff (reset) !rspLocal.valid);

endmodule

// File: ringStop.sv
/*
 * ring stop, two stages per hop on both rings
 * removes messages for this core, bounces lost requests back as
 * error responses and fills free slots with tile injections
 */
`timescale 1ns/1ps
module ringStop #(
    parameter ringPkg::tCoreId CoreId = 8'd1
) (
    input logic QClk,
    input logic reset,
    ringIf.dst  reqIn,
    ringIf.dst  rspIn,
    ringIf.src  reqOut,
    ringIf.src  rspOut,
    ringIf.src  reqLocal,    // requests for this tile
    ringIf.src  rspLocal,    // responses and bounces for this tile
    ringIf.dst  reqInj,
    ringIf.dst  rspInj,
    output logic reqInjTaken,
    output logic rspInjTaken
);
    import ringPkg::*;

    //==================================================
    // stage 1 (Q501) registers the ring input
    //==================================================
    logic      reqValidQ501, rspValidQ501;
    tRequestor reqRequestorQ501, rspRequestorQ501;
    tOpcode    reqOpcodeQ501, rspOpcodeQ501;
    tAddress   reqAddressQ501, rspAddressQ501;
    tData      reqDataQ501, rspDataQ501;

    always_ff @(posedge QClk) begin
        if (reset) begin
            reqValidQ501 <= 1'b0;
            rspValidQ501 <= 1'b0;
        end else begin
            reqValidQ501 <= reqIn.valid;
            rspValidQ501 <= rspIn.valid;
        end
        reqRequestorQ501 <= reqIn.requestor;
        reqOpcodeQ501    <= reqIn.opcode;
        reqAddressQ501   <= reqIn.address;
        reqDataQ501      <= reqIn.data;
        rspRequestorQ501 <= rspIn.requestor;
        rspOpcodeQ501    <= rspIn.opcode;
        rspAddressQ501   <= rspIn.address;
        rspDataQ501      <= rspIn.data;
    end

    // own request back at its stop means a full lap with no such target
    logic reqBounce, reqDeliver, reqDrop, rspDeliver;
    assign reqBounce  = reqValidQ501 && (coreOf(reqRequestorQ501) == CoreId);
    assign reqDeliver = reqValidQ501 && (targetOf(reqAddressQ501) == CoreId) && !reqBounce;
    assign reqDrop    = reqBounce || reqDeliver;
    // bounce wins rspLocal and a colliding response takes another lap
    assign rspDeliver = rspValidQ501 && (coreOf(rspRequestorQ501) == CoreId) && !reqBounce;

    assign reqLocal.valid     = reqDeliver;
    assign reqLocal.requestor = reqRequestorQ501;
    assign reqLocal.opcode    = reqOpcodeQ501;
    assign reqLocal.address   = reqAddressQ501;
    assign reqLocal.data      = reqDataQ501;

    assign rspLocal.valid     = reqBounce || rspDeliver;
    assign rspLocal.requestor = reqBounce ? reqRequestorQ501 : rspRequestorQ501;
    assign rspLocal.opcode    = reqBounce ? ((reqOpcodeQ501 == OpWrite) ? OpWrRsp : OpRdRsp)
                                          : rspOpcodeQ501;
    assign rspLocal.address   = reqBounce ? {reqAddressQ501[31:2], 2'b01}  // error flag
                                          : rspAddressQ501;
    assign rspLocal.data      = reqBounce ? '0 : rspDataQ501;

    // slot free when stage 1 is empty or leaving the ring
    assign reqInjTaken = reqInj.valid && (!reqValidQ501 || reqDrop);
    assign rspInjTaken = rspInj.valid && (!rspValidQ501 || rspDeliver);

    //==================================================
    // stage 2 (Q502) drives the ring output
    //==================================================
    logic      reqValidQ502, rspValidQ502;
    tRequestor reqRequestorQ502, rspRequestorQ502;
    tOpcode    reqOpcodeQ502, rspOpcodeQ502;
    tAddress   reqAddressQ502, rspAddressQ502;
    tData      reqDataQ502, rspDataQ502;

    always_ff @(posedge QClk) begin
        if (reset) begin
            reqValidQ502 <= 1'b0;
            rspValidQ502 <= 1'b0;
        end else begin
            reqValidQ502 <= (reqValidQ501 && !reqDrop) || reqInjTaken;
            rspValidQ502 <= (rspValidQ501 && !rspDeliver) || rspInjTaken;
        end
        if (reqInjTaken) begin
            reqRequestorQ502 <= reqInj.requestor;
            reqOpcodeQ502    <= reqInj.opcode;
            reqAddressQ502   <= reqInj.address;
            reqDataQ502      <= reqInj.data;
        end else begin
            reqRequestorQ502 <= reqRequestorQ501;
            reqOpcodeQ502    <= reqOpcodeQ501;
            reqAddressQ502   <= reqAddressQ501;
            reqDataQ502      <= reqDataQ501;
        end
        if (rspInjTaken) begin
            rspRequestorQ502 <= rspInj.requestor;
            rspOpcodeQ502    <= rspInj.opcode;
            rspAddressQ502   <= rspInj.address;
            rspDataQ502      <= rspInj.data;
        end else begin
            rspRequestorQ502 <= rspRequestorQ501;
            rspOpcodeQ502    <= rspOpcodeQ501;
            rspAddressQ502   <= rspAddressQ501;
            rspDataQ502      <= rspDataQ501;
        end
    end

    assign reqOut.valid     = reqValidQ502;
    assign reqOut.requestor = reqRequestorQ502;
    assign reqOut.opcode    = reqOpcodeQ502;
    assign reqOut.address   = reqAddressQ502;
    assign reqOut.data      = reqDataQ502;
    assign rspOut.valid     = rspValidQ502;
    assign rspOut.requestor = rspRequestorQ502;
    assign rspOut.opcode    = rspOpcodeQ502;
    assign rspOut.address   = rspAddressQ502;
    assign rspOut.data      = rspDataQ502;

    // request ring carries only requests
    assert property (@(posedge QClk) disable iff (reset)
        reqValidQ501 |-> (reqOpcodeQ501 == OpRead || reqOpcodeQ501 == OpWrite));
    // response ring carries only responses
    assert property (@(posedge QClk) disable iff (reset)
        rspValidQ501 |-> (rspOpcodeQ501 == OpRdRsp || rspOpcodeQ501 == OpWrRsp));

endmodule

// File: ringIf.sv
/*
 * ring link, one message per cycle
 * valid-only, no stall on the ring
 */
`timescale 1ns/1ps
interface ringIf;
    import ringPkg::*;

    logic      valid;      // message present this cycle
    tRequestor requestor;
    tOpcode    opcode;
    tAddress   address;
    tData      data;

    modport src (
        output valid, requestor, opcode, address, data
    );

    modport dst (
        input valid, requestor, opcode, address, data
    );

endinterface

// File: ringPkg.sv
/*
 * ring interconnect shared definitions
 * core ids, tags, field types, opcodes and field helpers
 */
package ringPkg;

    //==================================================
    // sizes
    //==================================================
    localparam int HostCoreId    = 1;                   // host tile core number
    localparam int NumMemTiles   = 3;                   // memory tiles take ids 2..4
    localparam int MemWords      = 16;                  // words per memory tile
    localparam int TagWidth      = 2;
    localparam int NumTags       = 2 ** TagWidth;
    localparam int RspQueueDepth = NumTags;             // one slot per tag, never overflows
    localparam int QueuePtrWidth = $clog2(RspQueueDepth);
    localparam int WordIdxWidth  = $clog2(MemWords);

    //==================================================
    // field types
    //==================================================
    typedef logic [7:0]                   tCoreId;
    typedef logic [TagWidth-1:0]          tTag;
    typedef logic [7+TagWidth:0]          tRequestor;  // {core id, tag}
    typedef logic [31:0]                  tAddress;    // [31:24] target core, [5:2] word
    typedef logic [31:0]                  tData;
    typedef logic [WordIdxWidth-1:0]      tWordIdx;

    // error response = rsp opcode with address bit 0 set
    typedef enum logic [1:0] {
        OpRead  = 2'd0,
        OpWrite = 2'd1,
        OpRdRsp = 2'd2,
        OpWrRsp = 2'd3
    } tOpcode;

    function automatic tCoreId coreOf(input tRequestor requestor);
        return requestor[TagWidth +: 8];
    endfunction

    function automatic tTag tagOf(input tRequestor requestor);
        return requestor[TagWidth-1:0];
    endfunction

    function automatic tCoreId targetOf(input tAddress address);
        return address[31:24];
    endfunction

    function automatic tWordIdx wordOf(input tAddress address);
        return address[2 +: WordIdxWidth];
    endfunction

    // priority pick, lowest index wins
    function automatic tTag lowestSet(input logic [NumTags-1:0] bits);
        tTag idx;
        idx = '0;
        for (int i = NumTags - 1; i >= 0; i--) begin
            if (bits[i]) idx = tTag'(i);
        end
        return idx;
    endfunction

endpackage
